//--- rtl/wide_addsub_settings.svh
// wide adder/subtractor settings for limb width, limb count and operand width
`ifndef WIDE_ADDSUB_SETTINGS_SVH
`define WIDE_ADDSUB_SETTINGS_SVH

// the 64-bit prefix adder fixes the limb width
`define WA_LIMB_W 64

// limbs per operand, lowest limb processed first
`define WA_NUM_LIMBS 4

// full operand and result width
`define WA_OP_W (`WA_LIMB_W * `WA_NUM_LIMBS)

`endif

//--- rtl/wide_addsub_pkg.sv
// wide adder/subtractor types for limbs, operands, limb index and sequencer state
`default_nettype none

`include "wide_addsub_settings.svh"

package wide_addsub_pkg;

   typedef logic [`WA_LIMB_W-1:0] limb_t;  // one limb through the prefix adder
   typedef logic [`WA_OP_W-1:0]   wide_t;  // full operand or result

   typedef logic [1:0] limb_idx_t;         // limb step count

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      FINISH
   } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/prefix_adder_64.sv
// 64-bit sparse parallel-prefix adder with group carries every fourth bit
`default_nettype none

module prefix_adder_64 (
   input  wide_addsub_pkg::limb_t a,
   input  wide_addsub_pkg::limb_t b,
   input  logic                   cin,
   output wide_addsub_pkg::limb_t sum,
   output logic                   cout
);

   // index 0 holds the carry-in as a generate with no propagate,
   // index i holds bit i-1 of the operands
   logic [64:0] p;
   logic [64:0] g;

   logic [31:0] g_pair;          // radix-2 level over bit pairs
   logic [31:0] p_pair;
   logic [15:0] g_nib;           // radix-2 level over nibbles
   logic [15:0] p_nib;

   logic [4:0][15:0] tree_g;     // nibble prefix tree, row 0 is the nibble level
   logic [3:0][15:0] tree_p;

   logic [15:0] grp_c;           // carry out of nibble k, prefix down to index 0
   logic [15:0] grp_cin;         // carry into nibble k
   logic [64:1] c;               // carry into each index

   assign p = {a ^ b, 1'b0};
   assign g = {a & b, cin};

   for (genvar i = 0; i < 32; i++) begin : g_pair_lvl
      assign g_pair[i] = g[2*i+1] | (p[2*i+1] & g[2*i]);
      assign p_pair[i] = p[2*i+1] & p[2*i];
   end

   for (genvar i = 0; i < 16; i++) begin : g_nib_lvl
      assign g_nib[i] = g_pair[2*i+1] | (p_pair[2*i+1] & g_pair[2*i]);
      assign p_nib[i] = p_pair[2*i+1] & p_pair[2*i];
   end

   assign tree_g[0] = g_nib;
   assign tree_p[0] = p_nib;

   // distances 1, 2, 4, 8 over the 16 nibbles
   for (genvar lv = 0; lv < 4; lv++) begin : g_tree
      for (genvar i = 0; i < 16; i++) begin : g_node
         if (i >= (1 << lv)) begin : g_merge
            assign tree_g[lv+1][i] = tree_g[lv][i] |
                                     (tree_p[lv][i] & tree_g[lv][i-(1<<lv)]);
            if (lv < 3) begin : g_merge_p
               assign tree_p[lv+1][i] = tree_p[lv][i] & tree_p[lv][i-(1<<lv)];
            end
         end else begin : g_pass
            assign tree_g[lv+1][i] = tree_g[lv][i];  // already reaches index 0
            if (lv < 3) begin : g_pass_p
               assign tree_p[lv+1][i] = tree_p[lv][i];
            end
         end
      end
   end

   assign grp_c   = tree_g[4];
   assign grp_cin = {grp_c[14:0], 1'b0};  // p[0] is zero, so nibble 0 needs no carry here

   // ripple inside each nibble from its group carry
   for (genvar k = 0; k < 16; k++) begin : g_local
      assign c[4*k+1] = g[4*k] | (p[4*k] & grp_cin[k]);
      assign c[4*k+2] = g_pair[2*k] | (p_pair[2*k] & grp_cin[k]);
      assign c[4*k+3] = g[4*k+2] | (p[4*k+2] & c[4*k+2]);
      assign c[4*k+4] = grp_c[k];
   end

   assign sum  = p[64:1] ^ c[64:1];
   assign cout = g[64] | (p[64] & c[64]);

endmodule

`default_nettype wire

//--- rtl/limb_counter.sv
// limb counter, steps through the limbs and flags the final one
`default_nettype none

`include "wide_addsub_settings.svh"

module limb_counter (
   input  logic clk,
   input  logic arst_n,
   input  logic load,
   input  logic step,
   output logic last
);

   import wide_addsub_pkg::*;

   limb_idx_t idx;  // limb currently at the adder

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         idx <= '0;
      end else if (load) begin
         idx <= '0;
      end else if (step) begin
         idx <= idx + 1'b1;  // wraps back to 0 after the top limb
      end
   end

   assign last = (idx == limb_idx_t'(`WA_NUM_LIMBS - 1));

endmodule

`default_nettype wire

//--- rtl/limb_seq_fsm.sv
// limb sequencer FSM, accepts start, strobes load and step, reports busy and done
`default_nettype none

module limb_seq_fsm (
   input  logic clk,
   input  logic arst_n,
   input  logic start,
   input  logic last,
   output logic load,
   output logic step,
   output logic busy,
   output logic done
);

   import wide_addsub_pkg::*;

   seq_state_t state;
   seq_state_t state_nxt;

   always_comb begin
      state_nxt = state;
      load      = 1'b0;
      step      = 1'b0;
      case (state)
         IDLE: begin
            if (start) begin
               load      = 1'b1;  // operands captured on the start edge
               state_nxt = RUN;
            end
         end
         RUN: begin
            step = 1'b1;
            if (last) begin
               state_nxt = FINISH;
            end
         end
         FINISH: begin
            state_nxt = IDLE;
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   // start is only looked at in IDLE, so a start while busy is dropped
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
         busy  <= 1'b0;
         done  <= 1'b0;
      end else begin
         state <= state_nxt;
         busy  <= (state_nxt != IDLE);
         done  <= (state_nxt == FINISH);  // one cycle, FINISH lasts one cycle
      end
   end

endmodule

`default_nettype wire

//--- rtl/limb_datapath.sv
// limb datapath, operand and result shift registers around the prefix adder
`default_nettype none

`include "wide_addsub_settings.svh"

module limb_datapath (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   load,
   input  logic                   step,
   input  logic                   sub,
   input  wide_addsub_pkg::wide_t a,
   input  wide_addsub_pkg::wide_t b,
   output wide_addsub_pkg::wide_t result,
   output logic                   carry_out,
   output logic                   overflow
);

   import wide_addsub_pkg::*;

   wide_t a_q;        // operands, lowest limb at the bottom
   wide_t b_q;        // already inverted for subtraction
   wide_t res_q;
   logic  carry_q;    // carry between limbs, final carry-out at the end
   logic  ovf_q;      // signed overflow of the last limb added

   limb_t a_lo;
   limb_t b_lo;
   limb_t limb_sum;
   logic  limb_cout;
   logic  limb_ovf;

   assign a_lo = a_q[`WA_LIMB_W-1:0];
   assign b_lo = b_q[`WA_LIMB_W-1:0];

   prefix_adder_64 i_prefix_adder_64 (
      .a    (a_lo),
      .b    (b_lo),
      .cin  (carry_q),
      .sum  (limb_sum),
      .cout (limb_cout)
   );

   // operand signs agree and the sum sign differs
   assign limb_ovf = (a_lo[`WA_LIMB_W-1] == b_lo[`WA_LIMB_W-1]) &&
                     (limb_sum[`WA_LIMB_W-1] != a_lo[`WA_LIMB_W-1]);

   always_ff @(posedge clk) begin
      if (load) begin
         a_q <= a;
         b_q <= sub ? ~b : b;  // a - b as a + ~b + 1
      end else if (step) begin
         a_q <= a_q >> `WA_LIMB_W;
         b_q <= b_q >> `WA_LIMB_W;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         carry_q <= 1'b0;
         ovf_q   <= 1'b0;
         res_q   <= '0;
      end else if (load) begin
         carry_q <= sub;  // the +1 of the subtraction
      end else if (step) begin
         carry_q <= limb_cout;
         ovf_q   <= limb_ovf;
         res_q   <= {limb_sum, res_q[`WA_OP_W-1:`WA_LIMB_W]};  // fill from the top
      end
   end

   assign result    = res_q;
   assign carry_out = carry_q;
   assign overflow  = ovf_q;

endmodule

`default_nettype wire

//--- rtl/wide_addsub.sv
// 256-bit limb-serial adder/subtractor, top level around sequencer, counter and datapath
`default_nettype none

module wide_addsub (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   start,
   input  logic                   sub,
   input  wide_addsub_pkg::wide_t a,
   input  wide_addsub_pkg::wide_t b,
   output wide_addsub_pkg::wide_t result,
   output logic                   carry_out,
   output logic                   overflow,
   output logic                   busy,
   output logic                   done
);

   logic load;  // operand capture, on the accepted start edge
   logic step;  // one limb per cycle
   logic last;  // final limb at the adder

   limb_seq_fsm i_limb_seq_fsm (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (start),
      .last   (last),
      .load   (load),
      .step   (step),
      .busy   (busy),
      .done   (done)
   );

   limb_counter i_limb_counter (
      .clk    (clk),
      .arst_n (arst_n),
      .load   (load),
      .step   (step),
      .last   (last)
   );

   limb_datapath i_limb_datapath (
      .clk       (clk),
      .arst_n    (arst_n),
      .load      (load),
      .step      (step),
      .sub       (sub),
      .a         (a),
      .b         (b),
      .result    (result),
      .carry_out (carry_out),
      .overflow  (overflow)
   );

endmodule

`default_nettype wire

//--- testbench/tb_wide_addsub.sv
// testbench checking the limb-serial 256-bit adder/subtractor against a reference model
`default_nettype none

`include "wide_addsub_settings.svh"

module tb_wide_addsub;

   timeunit 1ns;
   timeprecision 1ps;

   import wide_addsub_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int CLK_PERIOD   = 4;
   localparam int NUM_RAND     = 12;
   localparam int NUM_OPS      = 2 * NUM_RAND + 8;
   localparam int MSB          = `WA_OP_W - 1;
   localparam int WATCHDOG_NS  = CLK_PERIOD * (NUM_OPS * 8 + RESET_CYCLES);

   logic  clk;
   logic  arst_n;
   logic  start;
   logic  sub;
   wide_t a;
   wide_t b;
   wide_t result;
   logic  carry_out;
   logic  overflow;
   logic  busy;
   logic  done;

   integer seed;
   int     errors;
   int     ops_checked;
   int     phase;                     // negedges since start was seen and 0 when idle
   logic   have_result;
   wide_t  last_result;
   logic   last_carry;
   logic   last_ovf;
   logic [`WA_OP_W+1:0] exp_q[$];     // {overflow, carry, result} per accepted start
   logic [`WA_OP_W+1:0] exp_now;

   wide_addsub i_wide_addsub (
      .clk       (clk),
      .arst_n    (arst_n),
      .start     (start),
      .sub       (sub),
      .a         (a),
      .b         (b),
      .result    (result),
      .carry_out (carry_out),
      .overflow  (overflow),
      .busy      (busy),
      .done      (done)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // 257-bit sum plus signed overflow from the operand and result signs
   function automatic logic [`WA_OP_W+1:0] ref_addsub(input wide_t x, input wide_t y,
                                                    input logic do_sub);
      logic [`WA_OP_W:0] s;
      logic              v;
      if (do_sub) begin
         s = {1'b0, x} + {1'b0, ~y} + 1'b1;
         v = (x[MSB] != y[MSB]) && (s[MSB] != x[MSB]);
      end else begin
         s = {1'b0, x} + {1'b0, y};
         v = (x[MSB] == y[MSB]) && (s[MSB] != x[MSB]);
      end
      return {v, s};
   endfunction

   function automatic wide_t rand_wide();
      wide_t w;
      for (int i = 0; i < `WA_OP_W / 32; i++) begin
         w[32*i +: 32] = $random(seed);
      end
      return w;
   endfunction

   task automatic check_wide(input string name, input wide_t exp, input wide_t act);
      assert (act === exp) else begin
         errors++;
         $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      assert (act === exp) else begin
         errors++;
         $display("Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   task automatic check_reset_state();
      check_bit("busy", 1'b0, busy);
      check_bit("done", 1'b0, done);
      check_wide("result", '0, result);
      check_bit("carry_out", 1'b0, carry_out);
      check_bit("overflow", 1'b0, overflow);
   endtask

   // one operation from start to done with an optional second start while busy
   task automatic run_op(input wide_t x, input wide_t y, input logic do_sub,
                         input logic poke_busy, input int gap);
      int n;
      exp_q.push_back(ref_addsub(x, y, do_sub));
      @(posedge clk);
      start <= 1'b1;
      a     <= x;
      b     <= y;
      sub   <= do_sub;
      @(posedge clk);
      start <= 1'b0;
      if (poke_busy) begin
         @(posedge clk);
         start <= 1'b1;  // has to be dropped
         a     <= ~x;
         b     <= x ^ y;
         sub   <= ~do_sub;
         @(posedge clk);
         start <= 1'b0;
      end
      n = 0;
      @(negedge clk);
      while (!done && n < 16) begin
         @(negedge clk);
         n++;
      end
      assert (done) else begin
         errors++;
         $display("No done pulse within 16 cycles of start at %0d ns", $time);
      end
      repeat (1 + gap) @(negedge clk);
   endtask

   // follows each accepted start through the expected busy and done timing
   always @(negedge clk) begin
      if (arst_n) begin
         if ((phase == 0 || phase == 6) && have_result) begin
            check_wide("result", last_result, result);
            check_bit("carry_out", last_carry, carry_out);
            check_bit("overflow", last_ovf, overflow);
         end
         check_bit("busy", (phase >= 1 && phase <= 5), busy);
         check_bit("done", (phase == 5), done);
         if (done) begin  // oldest pending operation
            assert (exp_q.size() > 0) else begin
               errors++;
               $display("Done pulse at %0d ns with no operation pending", $time);
            end
            if (exp_q.size() > 0) begin
               exp_now = exp_q.pop_front();
               check_wide("result", exp_now[MSB:0], result);
               check_bit("carry_out", exp_now[`WA_OP_W], carry_out);
               check_bit("overflow", exp_now[`WA_OP_W+1], overflow);
               last_result = exp_now[MSB:0];
               last_carry  = exp_now[`WA_OP_W];
               last_ovf    = exp_now[`WA_OP_W+1];
               have_result = 1'b1;
               ops_checked++;
            end
         end
         if (phase >= 1 && phase <= 5) begin
            phase = phase + 1;
         end else if (start) begin
            phase = 1;  // taken at the coming edge
         end else begin
            phase = 0;
         end
      end
   end

   initial begin
      wide_t x;
      wide_t y;
      wide_t most_pos;
      wide_t most_neg;
      seed        = 72;
      errors      = 0;
      ops_checked = 0;
      phase       = 0;
      have_result = 1'b0;
      last_result = '0;
      last_carry  = 1'b0;
      last_ovf    = 1'b0;
      clk         = 1'b0;
      arst_n      = 1'b0;
      start       = 1'b0;
      sub         = 1'b0;
      a           = '0;
      b           = '0;
      most_pos    = {1'b0, {(`WA_OP_W-1){1'b1}}};
      most_neg    = {1'b1, {(`WA_OP_W-1){1'b0}}};

      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_reset_state();
      @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_reset_state();

      run_op('1, wide_t'(1), 1'b0, 1'b0, 0);  // carry through every limb
      run_op('0, '0, 1'b0, 1'b0, 1);
      for (int i = 0; i < NUM_RAND; i++) begin
         x = rand_wide();
         y = rand_wide();
         run_op(x, y, 1'b0, 1'b0, i % 2);
      end
      x = rand_wide();
      y = rand_wide();
      run_op(x, y, 1'b0, 1'b1, 0);

      x = rand_wide();
      run_op(x, x, 1'b1, 1'b0, 0);
      run_op(most_pos, most_pos, 1'b1, 1'b0, 1);
      run_op('0, wide_t'(1), 1'b1, 1'b0, 0);  // borrow through every limb
      run_op(most_pos, most_neg, 1'b1, 1'b0, 1);
      run_op(most_neg, '1, 1'b0, 1'b0, 0);
      for (int i = 0; i < NUM_RAND; i++) begin
         x = rand_wide();
         y = rand_wide();
         run_op(x, y, 1'b1, 1'b0, i % 2);
      end

      repeat (4) @(negedge clk);
      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d operations never completed", exp_q.size());
      end
      $display("Summary: %0d operations checked, %0d errors", ops_checked, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
      $display("Summary: %0d operations checked, %0d errors", ops_checked, errors);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- wide_addsub.f
+incdir+rtl
rtl/wide_addsub_pkg.sv
rtl/prefix_adder_64.sv
rtl/limb_counter.sv
rtl/limb_seq_fsm.sv
rtl/limb_datapath.sv
rtl/wide_addsub.sv
testbench/tb_wide_addsub.sv

//--- Bender.yml
package:
  name: wide_addsub

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/wide_addsub_pkg.sv
      - rtl/prefix_adder_64.sv
      - rtl/limb_counter.sv
      - rtl/limb_seq_fsm.sv
      - rtl/limb_datapath.sv
      - rtl/wide_addsub.sv

  - target: test
    files:
      - testbench/tb_wide_addsub.sv
